//--- design/rdma_pkg.sv
// ======================================================================
// Shared widths, offsets and payload structs of the send-queue gate
// Modules import this package for command and acknowledgement types
// ======================================================================
package rdma_pkg;

  // Lane layout
  localparam int N_LANES   = 4;
  localparam int LANE_BITS = 2;

  // Credit limit per lane
  localparam int RDMA_MAX_OUTSTANDING = 8;
  localparam int CNT_BITS             = 4;

  // Field widths
  localparam int RDMA_QPN_BITS    = 10;
  localparam int RDMA_OPCODE_BITS = 5;
  localparam int VADDR_BITS       = 48;
  localparam int LEN_BITS         = 28;
  localparam int RDMA_SNDRM_BITS  = 8;
  localparam int RDMA_MSN_BITS    = 24;

  // Flat engine command word, opcode at bit 0
  localparam int SQ_QPN_OFS   = RDMA_OPCODE_BITS;
  localparam int SQ_HOST_OFS  = SQ_QPN_OFS + RDMA_QPN_BITS;
  localparam int SQ_MODE_OFS  = SQ_HOST_OFS + 1;
  localparam int SQ_VADDR_OFS = SQ_MODE_OFS + 1;
  localparam int SQ_LEN_OFS   = SQ_VADDR_OFS + VADDR_BITS;
  localparam int RDMA_REQ_BITS = SQ_LEN_OFS + LEN_BITS;

  // Raw acknowledgement word, is_nak at bit 0
  localparam int ACK_QPN_OFS   = 1;
  localparam int ACK_SNDRM_OFS = ACK_QPN_OFS + RDMA_QPN_BITS;
  localparam int ACK_MSN_OFS   = ACK_SNDRM_OFS + RDMA_SNDRM_BITS;
  localparam int RDMA_ACK_BITS = ACK_MSN_OFS + RDMA_MSN_BITS;

  // User command
  typedef struct packed {
    logic [RDMA_OPCODE_BITS-1:0] opcode;
    logic [RDMA_QPN_BITS-1:0]    qpn;
    logic                        host;
    logic                        mode;
    logic [VADDR_BITS-1:0]       vaddr;
    logic [LEN_BITS-1:0]         len;
  } rdma_sq_t;

  // Acknowledgement from the packet engine
  typedef struct packed {
    logic                       is_nak;
    logic [RDMA_QPN_BITS-1:0]   qpn;
    logic [RDMA_SNDRM_BITS-1:0] syndrome;
    logic [RDMA_MSN_BITS-1:0]   msn;
  } rdma_ack_t;

endpackage

//--- design/sq_dispatch.sv
// ======================================================================
// Steers each user command to the credit lane picked by its qpn
// Combinational; the selected lane's ready is returned upstream
// ======================================================================
`timescale 1ns/1ps

module sq_dispatch (
  input  logic                            s_sq_valid,
  output logic                            s_sq_ready,
  input  rdma_pkg::rdma_sq_t              s_sq_data,

  output logic [rdma_pkg::N_LANES-1:0]    lane_in_valid,
  input  logic [rdma_pkg::N_LANES-1:0]    lane_in_ready,
  output rdma_pkg::rdma_sq_t              lane_in_data
);

  import rdma_pkg::*;

  logic [LANE_BITS-1:0] sel;

  // Lane taken from the low qpn bits
  assign sel = s_sq_data.qpn[LANE_BITS-1:0];

  // Payload fans out to all lanes, only one sees valid
  assign lane_in_data = s_sq_data;

  always_comb begin
    lane_in_valid      = '0;
    lane_in_valid[sel] = s_sq_valid;
  end

  assign s_sq_ready = lane_in_ready[sel];

endmodule

//--- design/sq_credit_lane.sv
// ======================================================================
// One credit lane: outstanding-command counter and one-entry register
// Admits a command only while credits remain and the register frees
// ======================================================================
`timescale 1ns/1ps

module sq_credit_lane (
  input  logic               nclk,
  input  logic               nresetn,

  // From dispatch
  input  logic               in_valid,
  output logic               in_ready,
  input  rdma_pkg::rdma_sq_t in_data,

  // To arbiter
  output logic               out_valid,
  input  logic               out_ready,
  output rdma_pkg::rdma_sq_t out_data,

  // Credit return pulse
  input  logic               ack
);

  import rdma_pkg::*;

  localparam logic [CNT_BITS-1:0] CREDIT_MAX = CNT_BITS'(RDMA_MAX_OUTSTANDING);

  logic [CNT_BITS-1:0] cnt_q;
  logic [CNT_BITS-1:0] cnt_d;
  logic                has_credit;
  logic                slot_free;
  logic                accept;
  logic                release_credit;

  assign has_credit = (cnt_q < CREDIT_MAX);

  // Register is empty or being drained this cycle
  assign slot_free = ~out_valid | out_ready;

  assign in_ready = has_credit & slot_free;
  assign accept   = in_valid & in_ready;

  // Stray ack on an idle lane is dropped
  assign release_credit = ack & (cnt_q != '0);

  always_comb begin
    cnt_d = cnt_q;
    case ({accept, release_credit})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      cnt_q     <= '0;
      out_valid <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      if (accept) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Payload register
  always_ff @(posedge nclk) begin
    if (accept) begin
      out_data <= in_data;
    end
  end

endmodule

//--- design/sq_arbiter.sv
// ======================================================================
// Round-robin drain of the credit lanes toward the packet engine
// Grants one lane per free slot and registers the flat command word
// ======================================================================
`timescale 1ns/1ps

module sq_arbiter (
  input  logic                                 nclk,
  input  logic                                 nresetn,

  input  logic [rdma_pkg::N_LANES-1:0]         lane_out_valid,
  output logic [rdma_pkg::N_LANES-1:0]         lane_out_ready,
  input  rdma_pkg::rdma_sq_t                   lane_out_data [rdma_pkg::N_LANES],

  output logic                                 m_sq_valid,
  input  logic                                 m_sq_ready,
  output logic [rdma_pkg::RDMA_REQ_BITS-1:0]   m_sq_data
);

  import rdma_pkg::*;

  logic [LANE_BITS-1:0] last_q;
  logic [LANE_BITS-1:0] grant_idx;
  logic [LANE_BITS-1:0] cand;
  logic                 found;
  logic                 take;
  logic                 grant;

  // Engine native layout, opcode in the low bits
  function automatic logic [RDMA_REQ_BITS-1:0] pack_req(input rdma_sq_t c);
    logic [RDMA_REQ_BITS-1:0] w;
    w = '0;
    w[0 +: RDMA_OPCODE_BITS]         = c.opcode;
    w[SQ_QPN_OFS +: RDMA_QPN_BITS]   = c.qpn;
    w[SQ_HOST_OFS]                   = c.host;
    w[SQ_MODE_OFS]                   = c.mode;
    w[SQ_VADDR_OFS +: VADDR_BITS]    = c.vaddr;
    w[SQ_LEN_OFS +: LEN_BITS]        = c.len;
    return w;
  endfunction

  // Search starts one past the last winner
  always_comb begin
    grant_idx = last_q;
    found     = 1'b0;
    cand      = last_q;
    for (int i = 1; i <= N_LANES; i++) begin
      cand = last_q + LANE_BITS'(i);
      if (!found && lane_out_valid[cand]) begin
        found     = 1'b1;
        grant_idx = cand;
      end
    end
  end

  assign take  = ~m_sq_valid | m_sq_ready;
  assign grant = take & found;

  always_comb begin
    lane_out_ready            = '0;
    lane_out_ready[grant_idx] = grant;
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      m_sq_valid <= 1'b0;
      last_q     <= '0;
    end else if (grant) begin
      m_sq_valid <= 1'b1;
      last_q     <= grant_idx;
    end else if (m_sq_ready) begin
      m_sq_valid <= 1'b0;
    end
  end

  always_ff @(posedge nclk) begin
    if (grant) begin
      m_sq_data <= pack_req(lane_out_data[grant_idx]);
    end
  end

endmodule

//--- design/ack_router.sv
// ======================================================================
// Unpacks engine acknowledgements into credit pulses for the lanes
// Also keeps running totals of all ACK words and of the NAKs among them
// ======================================================================
`timescale 1ns/1ps

module ack_router (
  input  logic                                nclk,
  input  logic                                nresetn,

  // Always accepted, no ready
  input  logic                                ack_valid,
  input  logic [rdma_pkg::RDMA_ACK_BITS-1:0]  ack_data,

  output logic [rdma_pkg::N_LANES-1:0]        lane_ack,
  output logic [31:0]                         ack_count,
  output logic [31:0]                         nak_count
);

  import rdma_pkg::*;

  rdma_ack_t            ack;
  logic [LANE_BITS-1:0] owner;

  // Raw word to struct
  always_comb begin
    ack.is_nak   = ack_data[0];
    ack.qpn      = ack_data[ACK_QPN_OFS +: RDMA_QPN_BITS];
    ack.syndrome = ack_data[ACK_SNDRM_OFS +: RDMA_SNDRM_BITS];
    ack.msn      = ack_data[ACK_MSN_OFS +: RDMA_MSN_BITS];
  end

  assign owner = ack.qpn[LANE_BITS-1:0];

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      lane_ack  <= '0;
      ack_count <= '0;
      nak_count <= '0;
    end else begin
      lane_ack <= '0;
      if (ack_valid) begin
        // NAK frees its credit as well
        lane_ack[owner] <= 1'b1;
        ack_count       <= ack_count + 32'd1;
        if (ack.is_nak) begin
          nak_count <= nak_count + 32'd1;
        end
      end
    end
  end

endmodule

//--- design/rdma_sq_gate.sv
// ======================================================================
// Send-queue admission gate between user commands and the packet engine
// Per-lane credit limit, round-robin output, ACK-driven credit return
// ======================================================================
`timescale 1ns/1ps

module rdma_sq_gate (
  input  logic                                nclk,
  input  logic                                nresetn,

  // User commands
  input  logic                                s_sq_valid,
  output logic                                s_sq_ready,
  input  rdma_pkg::rdma_sq_t                  s_sq_data,

  // Engine command word
  output logic                                m_sq_valid,
  input  logic                                m_sq_ready,
  output logic [rdma_pkg::RDMA_REQ_BITS-1:0]  m_sq_data,

  // Engine acknowledgements
  input  logic                                ack_valid,
  input  logic [rdma_pkg::RDMA_ACK_BITS-1:0]  ack_data,

  // Status
  output logic [31:0]                         ack_count,
  output logic [31:0]                         nak_count
);

  import rdma_pkg::*;

  logic [N_LANES-1:0] lane_in_valid;
  logic [N_LANES-1:0] lane_in_ready;
  rdma_sq_t           lane_in_data;

  logic [N_LANES-1:0] lane_out_valid;
  logic [N_LANES-1:0] lane_out_ready;
  rdma_sq_t           lane_out_data [N_LANES];

  logic [N_LANES-1:0] lane_ack;

  sq_dispatch sq_dispatch_i (
    .s_sq_valid    (s_sq_valid),
    .s_sq_ready    (s_sq_ready),
    .s_sq_data     (s_sq_data),
    .lane_in_valid (lane_in_valid),
    .lane_in_ready (lane_in_ready),
    .lane_in_data  (lane_in_data)
  );

  for (genvar i = 0; i < N_LANES; i++) begin : gen_lane
    sq_credit_lane sq_credit_lane_i (
      .nclk      (nclk),
      .nresetn   (nresetn),
      .in_valid  (lane_in_valid[i]),
      .in_ready  (lane_in_ready[i]),
      .in_data   (lane_in_data),
      .out_valid (lane_out_valid[i]),
      .out_ready (lane_out_ready[i]),
      .out_data  (lane_out_data[i]),
      .ack       (lane_ack[i])
    );
  end

  sq_arbiter sq_arbiter_i (
    .nclk           (nclk),
    .nresetn        (nresetn),
    .lane_out_valid (lane_out_valid),
    .lane_out_ready (lane_out_ready),
    .lane_out_data  (lane_out_data),
    .m_sq_valid     (m_sq_valid),
    .m_sq_ready     (m_sq_ready),
    .m_sq_data      (m_sq_data)
  );

  ack_router ack_router_i (
    .nclk      (nclk),
    .nresetn   (nresetn),
    .ack_valid (ack_valid),
    .ack_data  (ack_data),
    .lane_ack  (lane_ack),
    .ack_count (ack_count),
    .nak_count (nak_count)
  );

endmodule

//--- dv/tb_sq_model.svh
// ======================================================================
// Reference model of the send-queue gate, included inside the testbench
// Expected words per lane, credit bookkeeping, packing and compare tasks
// ======================================================================
`ifndef TB_SQ_MODEL_SVH
`define TB_SQ_MODEL_SVH

// Expected engine words per lane, oldest first
logic [RDMA_REQ_BITS-1:0] exp_q [N_LANES][$];

// Outstanding credits, and returns due at the next edge
int   credits [N_LANES];
logic ret_due [N_LANES];

logic [31:0] ack_exp;
logic [31:0] nak_exp;

function automatic int lane_of_cmd(input rdma_sq_t c);
  return int'(c.qpn[LANE_BITS-1:0]);
endfunction

// qpn sits right above is_nak in the raw word
function automatic int lane_of_ack(input logic [RDMA_ACK_BITS-1:0] w);
  return int'(w[1 +: LANE_BITS]);
endfunction

// Engine layout, opcode at bit 0 and len on top
function automatic logic [RDMA_REQ_BITS-1:0] pack_cmd(input rdma_sq_t c);
  return {c.len, c.vaddr, c.mode, c.host, c.qpn, c.opcode};
endfunction

function automatic logic [RDMA_ACK_BITS-1:0] pack_ack(input rdma_ack_t a);
  return {a.msn, a.syndrome, a.qpn, a.is_nak};
endfunction

// Accept adds a credit, a due return takes one unless none are out
function automatic int next_credits(input int cur, input logic accept, input logic ret);
  int nxt;
  nxt = cur;
  if (accept) begin
    nxt = nxt + 1;
  end
  if (ret && cur > 0) begin
    nxt = nxt - 1;
  end
  return nxt;
endfunction

function automatic int pending_words();
  int n;
  n = 0;
  for (int l = 0; l < N_LANES; l++) begin
    n = n + exp_q[l].size();
  end
  return n;
endfunction

task automatic check_cmd(input string name, input logic [RDMA_REQ_BITS-1:0] exp,
                         input logic [RDMA_REQ_BITS-1:0] act);
  if (act !== exp) begin
    abort_run($sformatf("Fail at %0t: %s expected %h got %h", $time, name, exp, act));
  end
endtask

task automatic check_count(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
  if (act !== exp) begin
    abort_run($sformatf("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act));
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    abort_run($sformatf("Fail at %0t: %s expected %b got %b", $time, name, exp, act));
  end
endtask

`endif

//--- dv/tb_rdma_sq_gate.sv
// ======================================================================
// Self-checking testbench for the send-queue gate
// Random commands and acknowledgements, checked against the model
// ======================================================================
`timescale 1ns/1ps

module tb_rdma_sq_gate;

  import rdma_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int N_RAND_CMDS = 40;
  localparam int N_BP_CMDS   = 6;
  localparam int WAIT_LIMIT  = 200;
  // Upper bounds of commands and acks over all tests
  localparam int MAX_CMDS    = N_RAND_CMDS + N_BP_CMDS + 2 * RDMA_MAX_OUTSTANDING + 8;
  localparam int MAX_ACKS    = N_RAND_CMDS + 6 * N_LANES * RDMA_MAX_OUTSTANDING;
  localparam int WDOG_CYCLES = (MAX_CMDS + MAX_ACKS) * 20;

  logic                     nclk;
  logic                     nresetn;
  logic                     s_sq_valid;
  logic                     s_sq_ready;
  rdma_sq_t                 s_sq_data;
  logic                     m_sq_valid;
  logic                     m_sq_ready;
  logic [RDMA_REQ_BITS-1:0] m_sq_data;
  logic                     ack_valid;
  logic [RDMA_ACK_BITS-1:0] ack_data;
  logic [31:0]              ack_count;
  logic [31:0]              nak_count;

  // Engine word seen during a stall
  logic                     hold_valid;
  logic [RDMA_REQ_BITS-1:0] hold_word;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  `include "tb_sq_model.svh"

  rdma_sq_gate rdma_sq_gate_i (
    .nclk       (nclk),
    .nresetn    (nresetn),
    .s_sq_valid (s_sq_valid),
    .s_sq_ready (s_sq_ready),
    .s_sq_data  (s_sq_data),
    .m_sq_valid (m_sq_valid),
    .m_sq_ready (m_sq_ready),
    .m_sq_data  (m_sq_data),
    .ack_valid  (ack_valid),
    .ack_data   (ack_data),
    .ack_count  (ack_count),
    .nak_count  (nak_count)
  );

  always #(CLK_PERIOD / 2) nclk = ~nclk;

  // Checker tracks both handshakes and the credit counts at each edge
  always @(posedge nclk) begin
    int   in_lane;
    int   out_lane;
    logic take;
    if (!nresetn) begin
      hold_valid = 1'b0;
      ack_exp    = '0;
      nak_exp    = '0;
      for (int l = 0; l < N_LANES; l++) begin
        credits[l] = 0;
        ret_due[l] = 1'b0;
      end
    end else begin
      if (hold_valid) begin
        check_flag("m_sq_valid", 1'b1, m_sq_valid);
        check_cmd("m_sq_data", hold_word, m_sq_data);
      end
      hold_valid = m_sq_valid & ~m_sq_ready;
      hold_word  = m_sq_data;
      if (m_sq_valid && m_sq_ready) begin
        out_lane = int'(m_sq_data[RDMA_OPCODE_BITS +: LANE_BITS]);
        if (exp_q[out_lane].size() == 0) begin
          abort_run($sformatf("Engine word %h matches no pending command", m_sq_data));
        end else begin
          check_cmd("m_sq_data", exp_q[out_lane].pop_front(), m_sq_data);
        end
      end
      in_lane = lane_of_cmd(s_sq_data);
      take    = s_sq_valid & s_sq_ready;
      // No credit left means no admission
      if (s_sq_valid && credits[in_lane] >= RDMA_MAX_OUTSTANDING) begin
        check_flag("s_sq_ready", 1'b0, s_sq_ready);
      end
      if (take) begin
        exp_q[in_lane].push_back(pack_cmd(s_sq_data));
      end
      for (int l = 0; l < N_LANES; l++) begin
        credits[l] = next_credits(credits[l], take && (l == in_lane), ret_due[l]);
        ret_due[l] = ack_valid && (lane_of_ack(ack_data) == l);
      end
      if (ack_valid) begin
        ack_exp = ack_exp + 32'd1;
        if (ack_data[0]) begin
          nak_exp = nak_exp + 32'd1;
        end
      end
    end
  end

  function automatic rdma_sq_t rand_cmd(input int lane);
    rdma_sq_t c;
    c.opcode = RDMA_OPCODE_BITS'($urandom());
    c.qpn    = {(RDMA_QPN_BITS-LANE_BITS)'($urandom()), LANE_BITS'(lane)};
    c.host   = 1'($urandom());
    c.mode   = 1'($urandom());
    c.vaddr  = VADDR_BITS'({$urandom(), $urandom()});
    c.len    = LEN_BITS'($urandom());
    return c;
  endfunction

  // Called and returns just after a falling edge
  task automatic try_cmd(input rdma_sq_t c, input int cycles, output logic ok);
    ok         = 1'b0;
    s_sq_valid = 1'b1;
    s_sq_data  = c;
    for (int i = 0; i < cycles && !ok; i++) begin
      @(posedge nclk);
      ok = s_sq_ready;
    end
    @(negedge nclk);
    s_sq_valid = 1'b0;
  endtask

  task automatic send_cmd(input rdma_sq_t c);
    logic ok;
    try_cmd(c, WAIT_LIMIT, ok);
    if (!ok) begin
      abort_run("Command was never accepted by the gate");
    end
  endtask

  task automatic send_ack(input int lane, input logic nak);
    rdma_ack_t a;
    a.is_nak   = nak;
    a.qpn      = {(RDMA_QPN_BITS-LANE_BITS)'($urandom()), LANE_BITS'(lane)};
    a.syndrome = RDMA_SNDRM_BITS'($urandom());
    a.msn      = RDMA_MSN_BITS'($urandom());
    ack_valid  = 1'b1;
    ack_data   = pack_ack(a);
    @(negedge nclk);
    ack_valid  = 1'b0;
  endtask

  // Return every outstanding credit as a random ACK or NAK
  task automatic release_all();
    int n;
    for (int l = 0; l < N_LANES; l++) begin
      n = credits[l];
      repeat (n) send_ack(l, 1'($urandom()));
    end
    repeat (2) @(negedge nclk);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending_words() != 0 || m_sq_valid) begin
      if (waited == WAIT_LIMIT) begin
        abort_run("Expected engine words never came out");
      end else begin
        waited++;
        @(negedge nclk);
      end
    end
  endtask

  // Next command waits once a lane is filled to its limit
  task automatic fill_and_block(input int lane);
    logic ok;
    repeat (RDMA_MAX_OUTSTANDING) send_cmd(rand_cmd(lane));
    wait_drain();
    try_cmd(rand_cmd(lane), 6, ok);
    check_flag("s_sq_ready", 1'b0, ok);
  endtask

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    abort_run("Watchdog expired before the tests finished");
  end

  initial begin
    rdma_sq_t c;
    rdma_sq_t pend [$];
    logic     ok;
    int       lane;
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'hd779));
    nclk       = 1'b0;
    nresetn    = 1'b0;
    s_sq_valid = 1'b0;
    s_sq_data  = '0;
    m_sq_ready = 1'b1;
    ack_valid  = 1'b0;
    ack_data   = '0;
    repeat (2) @(posedge nclk);
    @(negedge nclk);
    nresetn = 1'b1;

    // Reset state
    @(negedge nclk);
    check_flag("m_sq_valid", 1'b0, m_sq_valid);
    check_count("ack_count", 32'd0, ack_count);
    check_count("nak_count", 32'd0, nak_count);

    // Random commands on all lanes with the engine always ready
    for (int i = 0; i < N_RAND_CMDS; i++) begin
      lane = $urandom_range(N_LANES - 1, 0);
      if (credits[lane] >= RDMA_MAX_OUTSTANDING) begin
        send_ack(lane, 1'($urandom()));
      end
      send_cmd(rand_cmd(lane));
      if ($urandom_range(2, 0) == 0) begin
        send_ack($urandom_range(N_LANES - 1, 0), 1'($urandom()));
      end
    end
    wait_drain();

    // One ack after the credit limit admits exactly one more
    release_all();
    lane = $urandom_range(N_LANES - 1, 0);
    fill_and_block(lane);
    send_ack(lane, 1'b0);
    send_cmd(rand_cmd(lane));
    try_cmd(rand_cmd(lane), 6, ok);
    check_flag("s_sq_ready", 1'b0, ok);
    wait_drain();

    // Engine stalled while commands pile up in the lanes
    release_all();
    m_sq_ready = 1'b0;
    for (int i = 0; i < N_BP_CMDS; i++) begin
      c = rand_cmd($urandom_range(N_LANES - 1, 0));
      try_cmd(c, 3, ok);
      if (!ok) begin
        pend.push_back(c);
      end
    end
    repeat (4) @(negedge nclk);
    check_flag("m_sq_valid", 1'b1, m_sq_valid);
    m_sq_ready = 1'b1;
    while (pend.size() > 0) begin
      send_cmd(pend.pop_front());
    end
    wait_drain();

    // Totals over stray acks on lanes that hold no credit
    release_all();
    lane = $urandom_range(N_LANES - 1, 0);
    for (int i = 0; i < 12; i++) begin
      // Every other stray ack hits the lane filled below
      if (i % 2 == 0) begin
        send_ack(lane, 1'($urandom()));
      end else begin
        send_ack($urandom_range(N_LANES - 1, 0), 1'($urandom()));
      end
    end
    repeat (2) @(negedge nclk);
    check_count("ack_count", ack_exp, ack_count);
    check_count("nak_count", nak_exp, nak_count);
    fill_and_block(lane);
    wait_drain();

    $display("all tests passed");
    $finish;
  end

endmodule

//--- rdma_sq_gate.f
+incdir+dv
design/rdma_pkg.sv
design/sq_dispatch.sv
design/sq_credit_lane.sv
design/sq_arbiter.sv
design/ack_router.sv
design/rdma_sq_gate.sv
dv/tb_rdma_sq_gate.sv

//--- run.sh
#!/bin/sh
# Builds the send-queue gate testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_MSG="all tests passed"

if ! verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_rdma_sq_gate --Mdir obj_dir -o sim_tb \
    -f rdma_sq_gate.f; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "$PASS_MSG" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1
